//--- exu_pkg.sv
// Shared word types, opcodes and register layouts for the RV32IM execute unit
package exu_pkg;

    // ------------------------------------------------------------
    // Data widths fixed by RV32
    // ------------------------------------------------------------
    localparam int unsigned XLEN    = 32;
    localparam int unsigned SHAMT_W = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [2*XLEN-1:0] dword_t;

    // ------------------------------------------------------------
    // ALU operations, NOP must stay at zero
    // ------------------------------------------------------------
    typedef enum logic [4:0] {
        ALU_NOP = 5'd0,
        ADD     = 5'd1,
        SUB     = 5'd2,
        XOR     = 5'd3,
        OR      = 5'd4,
        AND     = 5'd5,
        SLL     = 5'd6,
        SRL     = 5'd7,
        SRA     = 5'd8,
        SLT     = 5'd9,
        SLTU    = 5'd10,
        MUL     = 5'd11,
        MULH    = 5'd12,
        MULHU   = 5'd13,
        MULHSU  = 5'd14,
        DIV     = 5'd15,
        DIVU    = 5'd16,
        REM     = 5'd17,
        REMU    = 5'd18
    } alu_op_e;

    // Which result the divider hands back
    typedef enum logic [1:0] {
        DIV_S = 2'd0,
        DIV_U = 2'd1,
        REM_S = 2'd2,
        REM_U = 2'd3
    } div_kind_e;

    // Extension register of the two-cycle path
    // Factor pair while a multiply is pending, shifted value during SRA
    typedef union packed {
        struct packed {
            word_t mul_a;
            word_t mul_b;
        } mul;
        dword_t sra;
    } ext_word_u;

endpackage

//--- div_if.sv
// Divide request and result channel between the ALU core and the divider
`timescale 1ns/1ps

interface div_if;

    // Request side, held by the core until res_ready
    logic               start;
    exu_pkg::div_kind_e kind;
    exu_pkg::word_t     dividend;
    exu_pkg::word_t     divisor;

    // Result side, one-cycle pulse from the divider
    logic               res_ready;
    exu_pkg::word_t     result;

    modport core (
        output start,
        output kind,
        output dividend,
        output divisor,
        input  res_ready,
        input  result
    );

    modport unit (
        input  start,
        input  kind,
        input  dividend,
        input  divisor,
        output res_ready,
        output result
    );

endinterface

//--- alu_core.sv
// Execute-stage ALU with single-cycle ops, two-cycle shift/multiply and divide sequencing
`timescale 1ns/1ps

module alu_core (
    input  logic             clk,
    input  logic             rst_n,
    input  exu_pkg::alu_op_e alu_op_i,
    input  exu_pkg::word_t   src1_i,
    input  exu_pkg::word_t   src2_i,
    div_if.core              div,
    output exu_pkg::word_t   result_o,
    output logic             zero_o,
    output logic             less_o,
    output logic             more_zero_o,
    output logic             busy_o
);

    // ------------------------------------------------------------
    // Internal signals
    // ------------------------------------------------------------
    logic                          pend_q;
    exu_pkg::ext_word_u            ext_q;
    exu_pkg::ext_word_u            ext_d;
    logic                          two_cycle;
    logic [exu_pkg::SHAMT_W-1:0]   shamt;
    exu_pkg::word_t                src1_abs;
    exu_pkg::word_t                src2_abs;
    exu_pkg::dword_t               sra_ext;
    exu_pkg::dword_t               prod;
    exu_pkg::dword_t               prod_neg;
    logic                          lt_s;
    logic                          lt_u;
    logic                          sign1;
    logic                          sign2;

    assign shamt = src2_i[exu_pkg::SHAMT_W-1:0];
    assign sign1 = src1_i[exu_pkg::XLEN-1];
    assign sign2 = src2_i[exu_pkg::XLEN-1];

    // Magnitudes for the signed multiply forms
    assign src1_abs = sign1 ? -src1_i : src1_i;
    assign src2_abs = sign2 ? -src2_i : src2_i;

    // Sign-extend to double width so a logical shift acts arithmetic
    assign sra_ext = {{exu_pkg::XLEN{sign1}}, src1_i};

    assign lt_s = $signed(src1_i) < $signed(src2_i);
    assign lt_u = src1_i < src2_i;

    // Unsigned product of the stored factors, used in the second cycle
    assign prod     = exu_pkg::dword_t'(ext_q.mul.mul_a) * exu_pkg::dword_t'(ext_q.mul.mul_b);
    assign prod_neg = -prod;

    // ------------------------------------------------------------
    // Extension register load value
    // ------------------------------------------------------------
    always_comb begin
        two_cycle         = 1'b0;
        ext_d.mul.mul_a   = src1_i;
        ext_d.mul.mul_b   = src2_i;
        case (alu_op_i)
            exu_pkg::SRA: begin
                two_cycle = 1'b1;
                ext_d.sra = sra_ext >> shamt;
            end
            exu_pkg::MUL,
            exu_pkg::MULHU: begin
                two_cycle = 1'b1;
            end
            exu_pkg::MULH: begin
                two_cycle       = 1'b1;
                ext_d.mul.mul_a = src1_abs;
                ext_d.mul.mul_b = src2_abs;
            end
            exu_pkg::MULHSU: begin
                two_cycle       = 1'b1;
                ext_d.mul.mul_a = src1_abs;
            end
            default: begin
                two_cycle = 1'b0;
            end
        endcase
    end

    // First cycle loads, second cycle presents and clears the flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
            ext_q  <= '0;
        end else if (pend_q) begin
            pend_q <= 1'b0;
        end else if (two_cycle) begin
            pend_q <= 1'b1;
            ext_q  <= ext_d;
        end
    end

    // ------------------------------------------------------------
    // Divider request
    // ------------------------------------------------------------
    assign div.dividend = src1_i;
    assign div.divisor  = src2_i;

    always_comb begin
        case (alu_op_i)
            exu_pkg::DIV:  div.kind = exu_pkg::DIV_S;
            exu_pkg::REM:  div.kind = exu_pkg::REM_S;
            exu_pkg::REMU: div.kind = exu_pkg::REM_U;
            default:       div.kind = exu_pkg::DIV_U;
        endcase
    end

    // ------------------------------------------------------------
    // Result, flags and busy
    // ------------------------------------------------------------
    always_comb begin
        result_o    = '0;
        zero_o      = 1'b0;
        less_o      = 1'b0;
        more_zero_o = 1'b0;
        busy_o      = two_cycle && !pend_q;
        div.start   = 1'b0;
        case (alu_op_i)
            exu_pkg::ADD: result_o = src1_i + src2_i;
            exu_pkg::SUB: begin
                result_o = src1_i - src2_i;
                zero_o   = (result_o == '0);
            end
            exu_pkg::XOR: result_o = src1_i ^ src2_i;
            exu_pkg::OR:  result_o = src1_i | src2_i;
            exu_pkg::AND: result_o = src1_i & src2_i;
            exu_pkg::SLL: result_o = src1_i << shamt;
            exu_pkg::SRL: result_o = src1_i >> shamt;
            exu_pkg::SLT: begin
                result_o    = exu_pkg::word_t'(lt_s);
                less_o      = lt_s;
                more_zero_o = !lt_s;
            end
            exu_pkg::SLTU: begin
                result_o    = exu_pkg::word_t'(lt_u);
                less_o      = lt_u;
                more_zero_o = !lt_u;
            end
            exu_pkg::SRA:   result_o = ext_q.sra[exu_pkg::XLEN-1:0];
            exu_pkg::MUL:   result_o = prod[exu_pkg::XLEN-1:0];
            exu_pkg::MULHU: result_o = prod[2*exu_pkg::XLEN-1:exu_pkg::XLEN];
            exu_pkg::MULH: begin
                // Product of magnitudes, negate when the signs differ
                result_o = (sign1 ^ sign2) ? prod_neg[2*exu_pkg::XLEN-1:exu_pkg::XLEN]
                                           : prod[2*exu_pkg::XLEN-1:exu_pkg::XLEN];
            end
            exu_pkg::MULHSU: begin
                result_o = sign1 ? prod_neg[2*exu_pkg::XLEN-1:exu_pkg::XLEN]
                                 : prod[2*exu_pkg::XLEN-1:exu_pkg::XLEN];
            end
            exu_pkg::DIV,
            exu_pkg::DIVU,
            exu_pkg::REM,
            exu_pkg::REMU: begin
                // Request stays up until the divider answers
                div.start = !div.res_ready;
                busy_o    = !div.res_ready;
                result_o  = div.result;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

//--- serial_divider.sv
// Radix-2 restoring divider producing RISC-V quotients and remainders
`timescale 1ns/1ps

module serial_divider (
    input  logic clk,
    input  logic rst_n,
    div_if.unit  div
);

    // ------------------------------------------------------------
    // Control and datapath registers
    // ------------------------------------------------------------
    logic               run_q;
    logic               fix_q;
    logic               ready_q;
    logic [4:0]         cnt_q;

    exu_pkg::word_t     quo_q;
    exu_pkg::word_t     rem_q;
    exu_pkg::word_t     dsr_q;
    exu_pkg::div_kind_e kind_q;
    logic               neg_quo_q;
    logic               neg_rem_q;
    exu_pkg::word_t     result_q;

    logic               idle;
    logic               take;
    logic               is_signed;
    logic               a_neg;
    logic               b_neg;
    logic [32:0]        partial;
    logic               fits;
    exu_pkg::word_t     quo_fix;
    exu_pkg::word_t     rem_fix;

    assign idle = !run_q && !fix_q;
    assign take = idle && div.start;

    assign is_signed = (div.kind == exu_pkg::DIV_S) || (div.kind == exu_pkg::REM_S);
    assign a_neg     = is_signed && div.dividend[exu_pkg::XLEN-1];
    assign b_neg     = is_signed && div.divisor[exu_pkg::XLEN-1];

    // One restoring step: shift in next dividend bit, try the subtract
    assign partial = {rem_q, quo_q[exu_pkg::XLEN-1]};
    assign fits    = partial >= {1'b0, dsr_q};

    assign quo_fix = neg_quo_q ? -quo_q : quo_q;
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    assign div.res_ready = ready_q;
    assign div.result    = result_q;

    // ------------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------------
    // Latch, 32 steps, sign fix, then a single res_ready cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q   <= 1'b0;
            fix_q   <= 1'b0;
            ready_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            ready_q <= fix_q;
            fix_q   <= 1'b0;
            if (take) begin
                run_q <= 1'b1;
                cnt_q <= '0;
            end else if (run_q) begin
                cnt_q <= cnt_q + 5'd1;
                if (cnt_q == 5'd31) begin
                    run_q <= 1'b0;
                    fix_q <= 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (take) begin
            quo_q     <= a_neg ? -div.dividend : div.dividend;
            dsr_q     <= b_neg ? -div.divisor : div.divisor;
            rem_q     <= '0;
            kind_q    <= div.kind;
            // Divide by zero leaves all ones, so never negate it
            neg_quo_q <= (a_neg ^ b_neg) && (div.divisor != '0);
            // Remainder takes the dividend sign, which also covers x/0
            neg_rem_q <= a_neg;
        end else if (run_q) begin
            quo_q <= {quo_q[exu_pkg::XLEN-2:0], fits};
            rem_q <= fits ? partial[exu_pkg::XLEN-1:0] - dsr_q : partial[exu_pkg::XLEN-1:0];
        end

        // Most-negative / -1 gives magnitude 2^31 with no negate,
        // which is the dividend itself, remainder zero
        if (fix_q) begin
            case (kind_q)
                exu_pkg::DIV_S,
                exu_pkg::DIV_U: result_q <= quo_fix;
                default:        result_q <= rem_fix;
            endcase
        end
    end

endmodule

//--- exu_top.sv
// Execute unit top joining the ALU core and the serial divider
`timescale 1ns/1ps

module exu_top (
    input  logic             clk,
    input  logic             rst_n,
    input  exu_pkg::alu_op_e alu_op_i,
    input  exu_pkg::word_t   src1_i,
    input  exu_pkg::word_t   src2_i,
    output exu_pkg::word_t   result_o,
    output logic             zero_o,
    output logic             less_o,
    output logic             more_zero_o,
    output logic             busy_o
);

    // ------------------------------------------------------------
    // Core to divider channel
    // ------------------------------------------------------------
    div_if u_div_if ();

    alu_core u_alu_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .alu_op_i    (alu_op_i),
        .src1_i      (src1_i),
        .src2_i      (src2_i),
        .div         (u_div_if.core),
        .result_o    (result_o),
        .zero_o      (zero_o),
        .less_o      (less_o),
        .more_zero_o (more_zero_o),
        .busy_o      (busy_o)
    );

    // Iterative unit for DIV, DIVU, REM, REMU
    serial_divider u_serial_divider (
        .clk   (clk),
        .rst_n (rst_n),
        .div   (u_div_if.unit)
    );

endmodule

//--- tb_exu.sv
// Testbench for the RV32IM execute unit, trace driven plus random multiply and divide
`timescale 1ns/1ps

module tb_exu;

    localparam int WAIT_LIMIT = 100;

    logic             clk;
    logic             rst_n;
    exu_pkg::alu_op_e alu_op;
    exu_pkg::word_t   src1;
    exu_pkg::word_t   src2;
    exu_pkg::word_t   result;
    logic             zero;
    logic             less;
    logic             more_zero;
    logic             busy;

    int               value_errors;
    int               latency_errors;
    int               timeout_errors;
    int               file_errors;
    bit               timed_out;
    logic [31:0]      rng_state;

    exu_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .alu_op_i    (alu_op),
        .src1_i      (src1),
        .src2_i      (src2),
        .result_o    (result),
        .zero_o      (zero),
        .less_o      (less),
        .more_zero_o (more_zero),
        .busy_o      (busy)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bit op_from_name(input string n, output exu_pkg::alu_op_e op);
        op = exu_pkg::ALU_NOP;
        case (n)
            "ADD":    op = exu_pkg::ADD;
            "SUB":    op = exu_pkg::SUB;
            "XOR":    op = exu_pkg::XOR;
            "OR":     op = exu_pkg::OR;
            "AND":    op = exu_pkg::AND;
            "SLL":    op = exu_pkg::SLL;
            "SRL":    op = exu_pkg::SRL;
            "SRA":    op = exu_pkg::SRA;
            "SLT":    op = exu_pkg::SLT;
            "SLTU":   op = exu_pkg::SLTU;
            "MUL":    op = exu_pkg::MUL;
            "MULH":   op = exu_pkg::MULH;
            "MULHU":  op = exu_pkg::MULHU;
            "MULHSU": op = exu_pkg::MULHSU;
            "DIV":    op = exu_pkg::DIV;
            "DIVU":   op = exu_pkg::DIVU;
            "REM":    op = exu_pkg::REM;
            "REMU":   op = exu_pkg::REMU;
            default:  return 1'b0;
        endcase
        return 1'b1;
    endfunction

    // Busy cycles seen before the result, divides wait 33 clocks after the latch
    function automatic int busy_cycles_for(input exu_pkg::alu_op_e op);
        case (op)
            exu_pkg::SRA, exu_pkg::MUL, exu_pkg::MULH,
            exu_pkg::MULHU, exu_pkg::MULHSU: return 1;
            exu_pkg::DIV, exu_pkg::DIVU,
            exu_pkg::REM, exu_pkg::REMU:     return 34;
            default:                         return 0;
        endcase
    endfunction

    task automatic check_word(input string name, input exu_pkg::word_t exp,
                              input exu_pkg::word_t act);
        if (act !== exp) begin
            $display("mismatch %s result: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flags(input string name, input logic exp_z, input logic exp_l,
                               input logic exp_m, input logic act_z, input logic act_l,
                               input logic act_m);
        if ({act_z, act_l, act_m} !== {exp_z, exp_l, exp_m}) begin
            $display("mismatch %s flags zero/less/more_zero: expected %b%b%b, actual %b%b%b",
                     name, exp_z, exp_l, exp_m, act_z, act_l, act_m);
            value_errors++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("mismatch %s busy cycles: expected %0d, actual %0d", name, exp, act);
            latency_errors++;
        end
    endtask

    // ------------------------------------------------------------
    // One operation: drive, wait for busy low, check
    // ------------------------------------------------------------
    task automatic run_op(input string name, input exu_pkg::alu_op_e op,
                          input exu_pkg::word_t a, input exu_pkg::word_t b,
                          input exu_pkg::word_t exp_res, input logic exp_z,
                          input logic exp_l, input logic exp_m);
        int busy_count;
        @(posedge clk);
        alu_op <= op;
        src1   <= a;
        src2   <= b;
        busy_count = 0;
        // Sample mid-cycle, away from the driving edge
        @(negedge clk);
        while (busy !== 1'b0 && busy_count < WAIT_LIMIT) begin
            busy_count++;
            @(negedge clk);
        end
        if (busy !== 1'b0) begin
            $display("Timeout: %s kept busy high for %0d cycles", name, WAIT_LIMIT);
            timeout_errors++;
            timed_out = 1'b1;
        end else begin
            check_word(name, exp_res, result);
            check_flags(name, exp_z, exp_l, exp_m, zero, less, more_zero);
            check_latency(name, busy_cycles_for(op), busy_count);
        end
    endtask

    task automatic run_trace();
        int               fd;
        int               line_no;
        int               op_count;
        string            line;
        string            op_name;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      expected;
        logic             z;
        logic             l;
        logic             m;
        exu_pkg::alu_op_e op;
        fd = $fopen("exu_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file exu_trace.txt");
            file_errors++;
            return;
        end
        line_no  = 0;
        op_count = 0;
        while (!timed_out && $fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            if ($sscanf(line, "%s %h %h %h %b %b %b", op_name, a, b, expected, z, l, m) != 7
                || !op_from_name(op_name, op)) begin
                $display("Trace line %0d could not be read: %s", line_no, line);
                file_errors++;
                continue;
            end
            op_count++;
            run_op($sformatf("line %0d %s", line_no, op_name), op, a, b, expected, z, l, m);
        end
        $fclose(fd);
        if (op_count == 0) begin
            $display("The trace file held no operations");
            file_errors++;
        end
    endtask

    // Random MUL, MULHU, DIVU, REMU with reference arithmetic
    task automatic run_random(input int count);
        logic [31:0]      a;
        logic [31:0]      b;
        logic [63:0]      prod;
        exu_pkg::word_t   expected;
        exu_pkg::alu_op_e op;
        for (int i = 0; i < count && !timed_out; i++) begin
            rng_state = lcg_next(rng_state);
            a = rng_state;
            rng_state = lcg_next(rng_state);
            b = rng_state;
            rng_state = lcg_next(rng_state);
            case (rng_state[31:30])
                2'd0: op = exu_pkg::MUL;
                2'd1: op = exu_pkg::MULHU;
                2'd2: op = exu_pkg::DIVU;
                default: op = exu_pkg::REMU;
            endcase
            // Smaller divisors give wider quotients
            if (op == exu_pkg::DIVU || op == exu_pkg::REMU)
                b = b >> rng_state[20:16];
            prod = {32'd0, a} * {32'd0, b};
            case (op)
                exu_pkg::MUL:   expected = prod[31:0];
                exu_pkg::MULHU: expected = prod[63:32];
                exu_pkg::DIVU:  expected = (b == 32'd0) ? 32'hffffffff : a / b;
                default:        expected = (b == 32'd0) ? a : a % b;
            endcase
            run_op($sformatf("random %0d %s", i, op.name()), op, a, b, expected,
                   1'b0, 1'b0, 1'b0);
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        alu_op         = exu_pkg::ALU_NOP;
        src1           = '0;
        src2           = '0;
        value_errors   = 0;
        latency_errors = 0;
        timeout_errors = 0;
        file_errors    = 0;
        timed_out      = 1'b0;
        rng_state      = 32'h09df4647;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        run_trace();
        if (!timed_out)
            run_random(40);
        $display("Errors: value %0d, latency %0d, timeout %0d, file %0d",
                 value_errors, latency_errors, timeout_errors, file_errors);
        if (value_errors + latency_errors + timeout_errors + file_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sim.f
exu_pkg.sv
div_if.sv
alu_core.sv
serial_divider.sv
exu_top.sv
tb_exu.sv

//--- Bender.yml
package:
  name: exu

sources:
  # Package and interface first, then the RTL blocks
  - files:
      - exu_pkg.sv
      - div_if.sv
      - alu_core.sv
      - serial_divider.sv
      - exu_top.sv

  # Testbench, simulation only
  - target: simulation
    files:
      - tb_exu.sv

//--- exu_trace.txt
# op src1 src2 expected_result zero less more_zero
# operands and result in hex, flags in binary, one operation per line
# single-cycle logic, arithmetic and shifts
ADD 00000005 00000007 0000000c 0 0 0
ADD ffffffff 00000001 00000000 0 0 0
SUB 00000010 00000003 0000000d 0 0 0
SUB 12345678 12345678 00000000 1 0 0
SUB 00000000 00000001 ffffffff 0 0 0
XOR f0f0f0f0 ff00ff00 0ff00ff0 0 0 0
OR f0f0f0f0 0f0f0000 fffff0f0 0 0 0
AND 12345678 0000ffff 00005678 0 0 0
SLL 00000001 0000001f 80000000 0 0 0
SLL 12345678 00000024 23456780 0 0 0
SRL 80000000 0000001f 00000001 0 0 0
SRL f0000000 00000104 0f000000 0 0 0
# signed and unsigned compares
SLT ffffffff 00000001 00000001 0 1 0
SLTU ffffffff 00000001 00000000 0 0 1
SLT 00000005 00000005 00000000 0 0 1
SLTU 00000003 80000000 00000001 0 1 0
SLT 80000000 7fffffff 00000001 0 1 0
# two-cycle arithmetic shift and multiplies
SRA 80000000 00000004 f8000000 0 0 0
SRA 7ffffff0 00000024 07ffffff 0 0 0
SRA 80000000 0000003f ffffffff 0 0 0
MUL 00000007 00000006 0000002a 0 0 0
MUL ffffffff ffffffff 00000001 0 0 0
MULH ffffffff ffffffff 00000000 0 0 0
MULHU ffffffff ffffffff fffffffe 0 0 0
MULH 80000000 80000000 40000000 0 0 0
MULHSU ffffffff ffffffff ffffffff 0 0 0
MULHSU 00000002 80000000 00000001 0 0 0
# divides with mixed signs
DIV 00000014 00000006 00000003 0 0 0
DIV ffffffec 00000006 fffffffd 0 0 0
REM ffffffec 00000006 fffffffe 0 0 0
REM 00000014 fffffffa 00000002 0 0 0
DIVU ffffffec 00000006 2aaaaaa7 0 0 0
REMU ffffffec 00000006 00000002 0 0 0
# divide by zero and overflow
DIV 12345678 00000000 ffffffff 0 0 0
REM 87654321 00000000 87654321 0 0 0
REMU 12345678 00000000 12345678 0 0 0
DIV 80000000 ffffffff 80000000 0 0 0
REM 80000000 ffffffff 00000000 0 0 0
# multiply, divide and add back to back
MUL 00010000 00010000 00000000 0 0 0
DIVU 00000064 00000007 0000000e 0 0 0
ADD 00000064 00000007 0000006b 0 0 0
